//--- hw/i3c_pkg.sv
// shared types, controller states and register offsets; imported by the csr, controller and phy
`default_nettype none

package i3c_pkg;

  typedef logic [6:0]  addr7_t;   // 7-bit target address
  typedef logic [7:0]  data8_t;   // one byte on the bus
  typedef logic [15:0] clkdiv_t;  // clock cycles per scl quarter period, minus one

  // command word, hwdata[15:9] addr, [8] rnw, [7:0] wdata
  typedef struct packed {
    addr7_t addr;
    logic   rnw;
    data8_t wdata;
  } i2c_cmd_t;

  // status word, hrdata[9] busy, [8] nack, [7:0] rdata
  typedef struct packed {
    logic   busy;
    logic   nack;   // address byte was not acknowledged
    data8_t rdata;
  } i2c_status_t;

  // line levels or requested drive levels, 1 = released
  typedef struct packed {
    logic scl;
    logic sda;
  } pad_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_ADDR,
    ST_ADDR_ACK,
    ST_DATA,
    ST_DATA_ACK,
    ST_STOP
  } ctrl_state_e;

  localparam int unsigned REG_CLKDIV = 32'h0;
  localparam int unsigned REG_CMD    = 32'h4;
  localparam int unsigned REG_STATUS = 32'h8;  // read only

endpackage

`default_nettype wire

//--- hw/ahb_csr.sv
// AHB-Lite register file holding the clock divider, the command word and the controller status
`timescale 1ns/1ps
`default_nettype none

module ahb_csr #(
  parameter int unsigned AHB_DATA_WIDTH = 32,
  parameter int unsigned AHB_ADDR_WIDTH = 32
) (
  input  logic                        clk_i,
  input  logic                        reset_i,

  input  logic [AHB_ADDR_WIDTH-1:0]   haddr_i,
  input  logic [1:0]                  htrans_i,
  input  logic [2:0]                  hsize_i,     // single word transfers only
  input  logic [2:0]                  hburst_i,    // bursts not supported
  input  logic [3:0]                  hprot_i,
  input  logic                        hwrite_i,
  input  logic [AHB_DATA_WIDTH-1:0]   hwdata_i,
  input  logic [AHB_DATA_WIDTH/8-1:0] hwstrb_i,
  input  logic                        hsel_i,
  input  logic                        hready_i,
  output logic [AHB_DATA_WIDTH-1:0]   hrdata_o,
  output logic                        hreadyout_o,
  output logic                        hresp_o,

  output i3c_pkg::i2c_cmd_t           cmd_o,
  output logic                        cmd_valid_o,
  output i3c_pkg::clkdiv_t            clkdiv_o,
  input  i3c_pkg::i2c_status_t        status_i
);
  import i3c_pkg::*;

  logic                      addr_phase;
  logic                      mapped;
  logic                      dphase_q;    // data phase of a mapped transfer
  logic                      err1_q;      // first error cycle, wait state
  logic                      err2_q;      // second error cycle
  logic [AHB_ADDR_WIDTH-1:0] addr_q;
  logic                      write_q;
  logic                      cmd_valid_q;
  logic                      wr_clkdiv;
  logic                      wr_cmd;
  clkdiv_t                   clkdiv_q;
  i2c_cmd_t                  cmd_q;

  assign addr_phase = hsel_i && hready_i && htrans_i[1];
  assign mapped     = (haddr_i == AHB_ADDR_WIDTH'(REG_CLKDIV)) ||
                      (haddr_i == AHB_ADDR_WIDTH'(REG_CMD)) ||
                      (haddr_i == AHB_ADDR_WIDTH'(REG_STATUS));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dphase_q <= 1'b0;
      err1_q   <= 1'b0;
      err2_q   <= 1'b0;
    end else begin
      dphase_q <= addr_phase && mapped;
      err1_q   <= addr_phase && !mapped;
      err2_q   <= err1_q;
    end
  end

  // address phase capture
  always_ff @(posedge clk_i) begin
    if (addr_phase) begin
      addr_q  <= haddr_i;
      write_q <= hwrite_i;
    end
  end

  assign wr_clkdiv = dphase_q && write_q && (addr_q == AHB_ADDR_WIDTH'(REG_CLKDIV));
  // a pending pulse also blocks, busy only rises a cycle after it
  assign wr_cmd    = dphase_q && write_q && (addr_q == AHB_ADDR_WIDTH'(REG_CMD)) &&
                     !status_i.busy && !cmd_valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      clkdiv_q    <= '0;
      cmd_valid_q <= 1'b0;
    end else begin
      if (wr_clkdiv && hwstrb_i[0]) clkdiv_q[7:0]  <= hwdata_i[7:0];
      if (wr_clkdiv && hwstrb_i[1]) clkdiv_q[15:8] <= hwdata_i[15:8];
      cmd_valid_q <= wr_cmd;  // one cycle after the data phase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_cmd) cmd_q <= i2c_cmd_t'(hwdata_i[$bits(i2c_cmd_t)-1:0]);
  end

  // read data in the data phase, no wait states
  always_comb begin
    hrdata_o = '0;
    if (dphase_q && !write_q) begin
      case (addr_q)
        AHB_ADDR_WIDTH'(REG_CLKDIV): hrdata_o = AHB_DATA_WIDTH'(clkdiv_q);
        AHB_ADDR_WIDTH'(REG_CMD):    hrdata_o = AHB_DATA_WIDTH'(cmd_q);
        AHB_ADDR_WIDTH'(REG_STATUS): hrdata_o = AHB_DATA_WIDTH'(status_i);
        default:                     hrdata_o = '0;
      endcase
    end
  end

  assign hreadyout_o = !err1_q;
  assign hresp_o     = err1_q || err2_q;

  assign cmd_o       = cmd_q;
  assign cmd_valid_o = cmd_valid_q;
  assign clkdiv_o    = clkdiv_q;

endmodule

`default_nettype wire

//--- hw/i2c_byte_ctrl.sv
// I2C master FSM; runs START, address byte, ack, one data byte, ack and STOP per command
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_ctrl (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  i3c_pkg::i2c_cmd_t    cmd_i,
  input  logic                 cmd_valid_i,
  input  i3c_pkg::clkdiv_t     clkdiv_i,
  input  i3c_pkg::pad_t        line_i,      // synchronized bus levels
  output i3c_pkg::pad_t        drive_o,     // 0 pulls the line low
  output i3c_pkg::i2c_status_t status_o
);
  import i3c_pkg::*;

  ctrl_state_e state_q;
  clkdiv_t     cnt_q;      // cycles within a quarter
  logic [1:0]  qtr_q;      // quarter within a bit cell
  logic [2:0]  bit_q;      // bits left in the byte
  logic        nack_q;
  data8_t      rdata_q;
  data8_t      shift_q;    // msb is on sda
  data8_t      wdata_q;
  logic        rnw_q;
  logic        tick;
  logic        sample;
  logic        bit_end;
  logic        scl_hi;

  assign tick    = (cnt_q == clkdiv_i);
  assign sample  = tick && (qtr_q == 2'd2);  // end of the high phase
  assign bit_end = tick && (qtr_q == 2'd3);

  // bit cell is low, high, high, low so sda only moves while scl is low
  assign scl_hi  = (qtr_q == 2'd1) || (qtr_q == 2'd2);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      qtr_q   <= '0;
      bit_q   <= '0;
      nack_q  <= 1'b0;
      rdata_q <= '0;
    end else if (state_q == ST_IDLE) begin
      cnt_q <= '0;
      qtr_q <= '0;
      if (cmd_valid_i) begin
        state_q <= ST_START;
        nack_q  <= 1'b0;
        rdata_q <= '0;
      end
    end else begin
      cnt_q <= tick ? '0 : cnt_q + 1'b1;
      if (tick) qtr_q <= qtr_q + 1'b1;

      if (bit_end) begin
        case (state_q)
          ST_START: begin
            state_q <= ST_ADDR;
            bit_q   <= 3'd7;
          end
          ST_ADDR: begin
            if (bit_q == 3'd0) state_q <= ST_ADDR_ACK;
            else               bit_q   <= bit_q - 1'b1;
          end
          ST_ADDR_ACK: begin
            if (nack_q) begin
              state_q <= ST_STOP;  // skip the data byte
            end else begin
              state_q <= ST_DATA;
              bit_q   <= 3'd7;
            end
          end
          ST_DATA: begin
            if (bit_q == 3'd0) state_q <= ST_DATA_ACK;
            else               bit_q   <= bit_q - 1'b1;
          end
          ST_DATA_ACK: state_q <= ST_STOP;
          ST_STOP:     state_q <= ST_IDLE;
          default:     state_q <= ST_IDLE;
        endcase
      end

      if (sample && state_q == ST_ADDR_ACK) nack_q <= line_i.sda;
      if (sample && state_q == ST_DATA && rnw_q) rdata_q <= {rdata_q[6:0], line_i.sda};
    end
  end

  // byte payload
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && cmd_valid_i) begin
      shift_q <= {cmd_i.addr, cmd_i.rnw};
      rnw_q   <= cmd_i.rnw;
      wdata_q <= cmd_i.wdata;
    end else if (bit_end && state_q == ST_ADDR_ACK) begin
      shift_q <= rnw_q ? 8'hff : wdata_q;  // all ones releases sda on a read
    end else if (bit_end && (state_q == ST_ADDR || state_q == ST_DATA)) begin
      shift_q <= {shift_q[6:0], 1'b1};
    end
  end

  always_comb begin
    drive_o.scl = 1'b1;
    drive_o.sda = 1'b1;
    case (state_q)
      ST_START: begin
        drive_o.scl = (qtr_q != 2'd3);
        drive_o.sda = (qtr_q == 2'd0);  // sda falls with scl high
      end
      ST_ADDR, ST_DATA: begin
        drive_o.scl = scl_hi;
        drive_o.sda = shift_q[7];
      end
      ST_ADDR_ACK, ST_DATA_ACK: begin
        drive_o.scl = scl_hi;           // sda released, read ends with nack
      end
      ST_STOP: begin
        drive_o.scl = (qtr_q != 2'd0);
        drive_o.sda = qtr_q[1];         // sda rises with scl high
      end
      default: begin
        drive_o.scl = 1'b1;
        drive_o.sda = 1'b1;
      end
    endcase
  end

  assign status_o.busy  = (state_q != ST_IDLE);
  assign status_o.nack  = nack_q;
  assign status_o.rdata = rdata_q;

endmodule

`default_nettype wire

//--- hw/i3c_phy.sv
// pad interface: synchronizes scl/sda inputs and turns requested levels into open-drain enables
`timescale 1ns/1ps
`default_nettype none

module i3c_phy (
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          scl_i,
  input  logic          sda_i,
  input  i3c_pkg::pad_t drive_i,
  output i3c_pkg::pad_t line_o,
  output logic          scl_o,
  output logic          scl_en_o,
  output logic          sda_o,
  output logic          sda_en_o
);
  import i3c_pkg::*;

  pad_t sync1_q;
  pad_t sync2_q;
  logic scl_en_q;
  logic sda_en_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q  <= '1;   // idle bus reads high
      sync2_q  <= '1;
      scl_en_q <= 1'b0;
      sda_en_q <= 1'b0;
    end else begin
      sync1_q.scl <= scl_i;
      sync1_q.sda <= sda_i;
      sync2_q     <= sync1_q;
      scl_en_q    <= !drive_i.scl;  // enable only to pull low
      sda_en_q    <= !drive_i.sda;
    end
  end

  assign line_o   = sync2_q;
  assign scl_o    = 1'b0;
  assign sda_o    = 1'b0;
  assign scl_en_o = scl_en_q;
  assign sda_en_o = sda_en_q;

endmodule

`default_nettype wire

//--- hw/i3c_phy_integration_wrapper.sv
// top level: connects the AHB registers, the I2C controller and the phy, and mirrors idle pads
`timescale 1ns/1ps
`default_nettype none

module i3c_phy_integration_wrapper #(
  parameter int unsigned AHB_DATA_WIDTH = 32,
  parameter int unsigned AHB_ADDR_WIDTH = 32
) (
  input  logic                        clk_i,
  input  logic                        reset_i,

  input  logic                        i3c_scl_i,
  output logic                        i3c_scl_o,
  output logic                        i3c_scl_en_o,
  input  logic                        i3c_sda_i,
  output logic                        i3c_sda_o,
  output logic                        i3c_sda_en_o,

  // AHB-Lite slave
  input  logic [AHB_ADDR_WIDTH-1:0]   haddr_i,
  input  logic [1:0]                  htrans_i,
  input  logic [2:0]                  hsize_i,
  input  logic [2:0]                  hburst_i,
  input  logic [3:0]                  hprot_i,
  input  logic                        hwrite_i,
  input  logic [AHB_DATA_WIDTH-1:0]   hwdata_i,
  input  logic [AHB_DATA_WIDTH/8-1:0] hwstrb_i,
  input  logic                        hsel_i,
  input  logic                        hready_i,
  output logic [AHB_DATA_WIDTH-1:0]   hrdata_o,
  output logic                        hreadyout_o,
  output logic                        hresp_o
);
  import i3c_pkg::*;

  i2c_cmd_t    cmd;
  logic        cmd_valid;
  clkdiv_t     clkdiv;
  i2c_status_t status;
  pad_t        drive;
  pad_t        line;
  logic        scl_int;
  logic        sda_int;

  // pad outputs follow the pad inputs while not driven
  assign i3c_scl_o = i3c_scl_en_o ? scl_int : i3c_scl_i;
  assign i3c_sda_o = i3c_sda_en_o ? sda_int : i3c_sda_i;

  ahb_csr #(
    .AHB_DATA_WIDTH(AHB_DATA_WIDTH),
    .AHB_ADDR_WIDTH(AHB_ADDR_WIDTH)
  ) ahb_csr_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .haddr_i    (haddr_i),
    .htrans_i   (htrans_i),
    .hsize_i    (hsize_i),
    .hburst_i   (hburst_i),
    .hprot_i    (hprot_i),
    .hwrite_i   (hwrite_i),
    .hwdata_i   (hwdata_i),
    .hwstrb_i   (hwstrb_i),
    .hsel_i     (hsel_i),
    .hready_i   (hready_i),
    .hrdata_o   (hrdata_o),
    .hreadyout_o(hreadyout_o),
    .hresp_o    (hresp_o),
    .cmd_o      (cmd),
    .cmd_valid_o(cmd_valid),
    .clkdiv_o   (clkdiv),
    .status_i   (status)
  );

  i2c_byte_ctrl i2c_byte_ctrl_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cmd_i      (cmd),
    .cmd_valid_i(cmd_valid),
    .clkdiv_i   (clkdiv),
    .line_i     (line),
    .drive_o    (drive),
    .status_o   (status)
  );

  i3c_phy i3c_phy_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .scl_i   (i3c_scl_i),
    .sda_i   (i3c_sda_i),
    .drive_i (drive),
    .line_o  (line),
    .scl_o   (scl_int),
    .scl_en_o(i3c_scl_en_o),
    .sda_o   (sda_int),
    .sda_en_o(i3c_sda_en_o)
  );

endmodule

`default_nettype wire

//--- tb/i2c_target_model.sv
// behavioral I2C target for the testbench; acks one address, stores a written byte, returns a read byte
`timescale 1ns/1ps
`default_nettype none

module i2c_target_model #(
  parameter i3c_pkg::addr7_t ADDR      = 7'h5a,
  parameter i3c_pkg::data8_t READ_BYTE = 8'hc3
) (
  input  wire             scl_i,
  input  wire             sda_i,
  output logic            sda_low_o,    // 1 pulls sda low
  output i3c_pkg::data8_t stored_o,     // last byte written to this target
  output int unsigned     store_cnt_o,
  output int unsigned     start_cnt_o
);
  import i3c_pkg::*;

  logic   active;     // between start and stop
  logic   selected;
  logic   rnw;
  int     bit_cnt;    // scl rising edges in the current byte and its ack
  int     byte_idx;   // 0 address, 1 data
  data8_t shift;

  initial begin
    sda_low_o   = 1'b0;
    stored_o    = '0;
    store_cnt_o = 0;
    start_cnt_o = 0;
    active      = 1'b0;
    selected    = 1'b0;
    rnw         = 1'b0;
    bit_cnt     = 0;
    byte_idx    = 0;
    shift       = '0;
  end

  // start condition, sda falls while scl is high
  always @(negedge sda_i) begin
    if (scl_i === 1'b1) begin
      active      = 1'b1;
      selected    = 1'b0;
      bit_cnt     = 0;
      byte_idx    = 0;
      start_cnt_o = start_cnt_o + 1;
    end
  end

  // stop condition
  always @(posedge sda_i) begin
    if (scl_i === 1'b1) begin
      active    = 1'b0;
      sda_low_o = 1'b0;
    end
  end

  always @(posedge scl_i) begin
    if (active) begin
      if (bit_cnt < 8) shift = {shift[6:0], sda_i};  // msb first
      bit_cnt = bit_cnt + 1;
    end
  end

  // sda only moves here, while scl is low
  always @(negedge scl_i) begin
    if (active) begin
      if (bit_cnt == 8) begin
        if (byte_idx == 0) begin
          selected  = (shift[7:1] == ADDR);
          rnw       = shift[0];
          sda_low_o = selected;             // address ack
        end else if (selected && !rnw) begin
          stored_o    = shift;
          store_cnt_o = store_cnt_o + 1;
          sda_low_o   = 1'b1;               // data ack
        end else begin
          sda_low_o = 1'b0;                 // read byte done, master answers
        end
      end else if (bit_cnt == 9) begin
        bit_cnt   = 0;
        byte_idx  = byte_idx + 1;
        sda_low_o = selected && rnw && (byte_idx == 1) && !READ_BYTE[7];
      end else if (selected && rnw && byte_idx == 1 && bit_cnt > 0) begin
        sda_low_o = !READ_BYTE[7 - bit_cnt];
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_i3c_phy_integration_wrapper.sv
// testbench for the wrapper that checks the AHB registers and runs directed I2C transfers against a target model
`timescale 1ns/1ps
`default_nettype none

module tb_i3c_phy_integration_wrapper;
  import i3c_pkg::*;

  localparam int unsigned DW         = 32;
  localparam int unsigned AW         = 32;
  localparam int unsigned CLK_NS     = 10;
  localparam int unsigned DIV_FAST   = 4;
  localparam int unsigned DIV_SLOW   = 9;
  localparam int unsigned POLL_LIMIT = 1000;
  // a transfer is 20 bit cells of 4 quarters
  localparam int unsigned XFER_NS     = 20 * 4 * (DIV_SLOW + 1) * CLK_NS;
  localparam int unsigned WATCHDOG_NS = 5 * XFER_NS * 5;  // five transfers with a margin of 5
  localparam addr7_t      TGT_ADDR    = 7'h5a;
  localparam data8_t      TGT_RDATA   = 8'hc3;

  logic          clk;
  logic          reset;
  logic [AW-1:0] haddr;
  logic [1:0]    htrans;
  logic [2:0]    hsize;
  logic [2:0]    hburst;
  logic [3:0]    hprot;
  logic          hwrite;
  logic [DW-1:0] hwdata;
  logic [DW/8-1:0] hwstrb;
  logic          hsel;
  logic          hready;
  logic [DW-1:0] hrdata;
  logic          hreadyout;
  logic          hresp;
  logic          scl_o;
  logic          scl_en;
  logic          sda_o;
  logic          sda_en;
  logic          ext_scl_low;   // a third party pulling the lines
  logic          ext_sda_low;
  logic          tgt_sda_low;
  data8_t        stored_byte;
  int unsigned   store_cnt;
  int unsigned   start_cnt;
  wire           scl_bus;
  wire           sda_bus;
  integer        seed;
  int            errors;
  int            checks;

  // open-drain wired-and
  assign scl_bus = !((scl_en === 1'b1 && scl_o === 1'b0) || ext_scl_low);
  assign sda_bus = !((sda_en === 1'b1 && sda_o === 1'b0) || ext_sda_low || tgt_sda_low);

  i3c_phy_integration_wrapper #(
    .AHB_DATA_WIDTH(DW),
    .AHB_ADDR_WIDTH(AW)
  ) i3c_phy_integration_wrapper_inst (
    .clk_i       (clk),
    .reset_i     (reset),
    .i3c_scl_i   (scl_bus),
    .i3c_scl_o   (scl_o),
    .i3c_scl_en_o(scl_en),
    .i3c_sda_i   (sda_bus),
    .i3c_sda_o   (sda_o),
    .i3c_sda_en_o(sda_en),
    .haddr_i     (haddr),
    .htrans_i    (htrans),
    .hsize_i     (hsize),
    .hburst_i    (hburst),
    .hprot_i     (hprot),
    .hwrite_i    (hwrite),
    .hwdata_i    (hwdata),
    .hwstrb_i    (hwstrb),
    .hsel_i      (hsel),
    .hready_i    (hready),
    .hrdata_o    (hrdata),
    .hreadyout_o (hreadyout),
    .hresp_o     (hresp)
  );

  i2c_target_model #(
    .ADDR     (TGT_ADDR),
    .READ_BYTE(TGT_RDATA)
  ) target_model_inst (
    .scl_i      (scl_bus),
    .sda_i      (sda_bus),
    .sda_low_o  (tgt_sda_low),
    .stored_o   (stored_byte),
    .store_cnt_o(store_cnt),
    .start_cnt_o(start_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

  task automatic check_bit(input logic got, input logic exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s, got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_data8(input data8_t got, input data8_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_word(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                            input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_status(input i2c_status_t got, input i2c_status_t exp,
                              input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s, got busy %b nack %b rdata %h, expected busy %b nack %b rdata %h",
               $time, msg, got.busy, got.nack, got.rdata, exp.busy, exp.nack, exp.rdata);
    end
  endtask

  task automatic check_period(input time got, input time exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s, got %0d ns expected %0d ns", $time, msg, got, exp);
    end
  endtask

  function automatic i2c_status_t make_status(input logic busy, input logic nack,
                                              input data8_t rdata);
    i2c_status_t s;
    s.busy  = busy;
    s.nack  = nack;
    s.rdata = rdata;
    return s;
  endfunction

  // strobed byte lanes take the new data and the divider keeps 16 bits
  function automatic logic [DW-1:0] merge_strobe(input logic [DW-1:0] old_val,
                                                  input logic [DW-1:0] new_val,
                                                  input logic [DW/8-1:0] strb);
    logic [DW-1:0] res;
    res = old_val;
    for (int i = 0; i < DW / 8; i++) begin
      if (strb[i]) res[i*8 +: 8] = new_val[i*8 +: 8];
    end
    return res & 32'h0000_ffff;
  endfunction

  task automatic wait_ready(output logic resp);
    int n;
    n = 0;
    while (hreadyout !== 1'b1 && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (hreadyout !== 1'b1) begin
      errors++;
      $display("the AHB slave never raised hreadyout, at %0t", $time);
    end
    resp = hresp;
  endtask

  task automatic ahb_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                           input logic [DW/8-1:0] strb, output logic resp);
    @(negedge clk);
    haddr  = addr;
    htrans = 2'b10;                // NONSEQ
    hwrite = 1'b1;
    hsel   = 1'b1;
    @(negedge clk);                // data phase
    htrans = 2'b00;
    hwrite = 1'b0;
    hsel   = 1'b0;
    hwdata = data;
    hwstrb = strb;
    wait_ready(resp);
  endtask

  task automatic ahb_read(input logic [AW-1:0] addr, output logic [DW-1:0] data,
                          output logic resp);
    @(negedge clk);
    haddr  = addr;
    htrans = 2'b10;
    hwrite = 1'b0;
    hsel   = 1'b1;
    @(negedge clk);
    htrans = 2'b00;
    hsel   = 1'b0;
    wait_ready(resp);
    data = hrdata;
  endtask

  task automatic read_status(output i2c_status_t st);
    logic [DW-1:0] w;
    logic          resp;
    ahb_read(REG_STATUS, w, resp);
    check_bit(resp, 1'b0, "REG_STATUS read response");
    st = i2c_status_t'(w[$bits(i2c_status_t)-1:0]);
  endtask

  task automatic send_cmd(input addr7_t addr, input logic rnw, input data8_t wdata);
    i2c_cmd_t cmd;
    logic     resp;
    cmd.addr  = addr;
    cmd.rnw   = rnw;
    cmd.wdata = wdata;
    ahb_write(REG_CMD, DW'(cmd), 4'hf, resp);
    check_bit(resp, 1'b0, "REG_CMD write response");
  endtask

  // poll until busy falls
  task automatic wait_idle(output i2c_status_t st, output logic saw_busy);
    int polls;
    polls    = 0;
    saw_busy = 1'b0;
    do begin
      read_status(st);
      if (st.busy) saw_busy = 1'b1;
      polls++;
    end while (st.busy && polls < POLL_LIMIT);
    if (st.busy) begin
      errors++;
      $display("transfer still busy after %0d status polls, at %0t", polls, $time);
    end
  endtask

  task automatic test_reset_state();
    i2c_status_t st;
    check_bit(scl_en, 1'b0, "scl enable after reset");
    check_bit(sda_en, 1'b0, "sda enable after reset");
    check_bit(scl_o, 1'b1, "scl pad mirrors idle input");
    check_bit(sda_o, 1'b1, "sda pad mirrors idle input");
    @(negedge clk);
    ext_scl_low = 1'b1;
    @(negedge clk);
    check_bit(scl_o, 1'b0, "scl pad mirrors low input");
    ext_sda_low = 1'b1;            // scl already low so no start
    @(negedge clk);
    check_bit(sda_o, 1'b0, "sda pad mirrors low input");
    ext_sda_low = 1'b0;
    @(negedge clk);
    ext_scl_low = 1'b0;
    @(negedge clk);
    check_bit(scl_o, 1'b1, "scl pad follows released input");
    check_bit(sda_o, 1'b1, "sda pad follows released input");
    read_status(st);
    check_status(st, make_status(1'b0, 1'b0, 8'h00), "status after reset");
  endtask

  task automatic test_clkdiv_strobes();
    logic [DW-1:0] exp;
    logic [DW-1:0] got;
    logic          resp;
    exp = merge_strobe('0, 32'h0000_1234, 4'b1111);
    ahb_write(REG_CLKDIV, 32'h0000_1234, 4'b1111, resp);
    ahb_read(REG_CLKDIV, got, resp);
    check_word(got, exp, "clkdiv full write");
    exp = merge_strobe(exp, 32'hffff_ab56, 4'b0001);
    ahb_write(REG_CLKDIV, 32'hffff_ab56, 4'b0001, resp);
    ahb_read(REG_CLKDIV, got, resp);
    check_word(got, exp, "clkdiv low byte strobe");
    exp = merge_strobe(exp, 32'h0000_77aa, 4'b0010);
    ahb_write(REG_CLKDIV, 32'h0000_77aa, 4'b0010, resp);
    ahb_read(REG_CLKDIV, got, resp);
    check_word(got, exp, "clkdiv high byte strobe");
  endtask

  task automatic test_unmapped();
    logic [DW-1:0] got;
    logic          resp;
    i2c_status_t   st;
    ahb_write(32'h10, 32'hdead_beef, 4'hf, resp);
    check_bit(resp, 1'b1, "unmapped write error response");
    ahb_read(32'h0c, got, resp);
    check_bit(resp, 1'b1, "unmapped read error response");
    ahb_write(REG_STATUS, 32'h0000_03ff, 4'hf, resp);
    check_bit(resp, 1'b0, "REG_STATUS write response");
    read_status(st);
    check_status(st, make_status(1'b0, 1'b0, 8'h00), "status is read only");
  endtask

  task automatic test_write_xfer(input int unsigned div);
    integer      rnd;
    data8_t      wdata;
    int unsigned stores;
    logic        resp;
    logic        saw_busy;
    time         t_rise;
    i2c_status_t st;
    ahb_write(REG_CLKDIV, DW'(div), 4'hf, resp);
    rnd    = $random(seed);
    wdata  = rnd[7:0];
    stores = store_cnt;
    send_cmd(TGT_ADDR, 1'b0, wdata);
    @(posedge scl_bus);            // first address bit
    t_rise = $time;
    @(posedge scl_bus);
    check_period($time - t_rise, 4 * (div + 1) * CLK_NS, "scl period set by clkdiv");
    wait_idle(st, saw_busy);
    check_bit(saw_busy, 1'b1, "busy seen during write");
    check_bit(st.nack, 1'b0, "write address acked");
    check_bit(store_cnt == stores + 1, 1'b1, "target stored one byte");
    check_data8(stored_byte, wdata, "target stored byte");
  endtask

  task automatic test_read_xfer();
    logic        saw_busy;
    i2c_status_t st;
    send_cmd(TGT_ADDR, 1'b1, 8'h00);
    wait_idle(st, saw_busy);
    check_bit(saw_busy, 1'b1, "busy seen during read");
    check_status(st, make_status(1'b0, 1'b0, TGT_RDATA), "status after read");
  endtask

  task automatic test_absent_and_busy();
    int unsigned   starts;
    int unsigned   stores;
    logic          saw_busy;
    logic          resp;
    logic [DW-1:0] got;
    i2c_cmd_t      first;
    i2c_status_t   st;
    starts      = start_cnt;
    stores      = store_cnt;
    first.addr  = 7'h21;
    first.rnw   = 1'b0;
    first.wdata = 8'h3c;
    send_cmd(first.addr, first.rnw, first.wdata);
    read_status(st);
    check_bit(st.busy, 1'b1, "busy after command");
    send_cmd(TGT_ADDR, 1'b0, 8'h99);   // must be dropped
    ahb_read(REG_CMD, got, resp);
    check_word(got, DW'(first), "command register keeps the first command");
    wait_idle(st, saw_busy);
    check_bit(st.nack, 1'b1, "absent address gives nack");
    check_bit(start_cnt == starts + 1, 1'b1, "exactly one transaction on the bus");
    check_bit(store_cnt == stores, 1'b1, "target stored nothing");
  endtask

  initial begin
    seed        = 32'h2339;
    errors      = 0;
    checks      = 0;
    reset       = 1'b1;
    haddr       = '0;
    htrans      = 2'b00;
    hsize       = 3'b010;     // word
    hburst      = 3'b000;
    hprot       = 4'b0011;
    hwrite      = 1'b0;
    hwdata      = '0;
    hwstrb      = '0;
    hsel        = 1'b0;
    hready      = 1'b1;
    ext_scl_low = 1'b0;
    ext_sda_low = 1'b0;
    repeat (3) @(negedge clk);
    reset = 1'b0;

    test_reset_state();
    test_clkdiv_strobes();
    test_unmapped();
    test_write_xfer(DIV_FAST);
    test_read_xfer();
    test_absent_and_busy();
    test_write_xfer(DIV_SLOW);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
hw/i3c_pkg.sv
hw/ahb_csr.sv
hw/i2c_byte_ctrl.sv
hw/i3c_phy.sv
hw/i3c_phy_integration_wrapper.sv
tb/i2c_target_model.sv
tb/tb_i3c_phy_integration_wrapper.sv

//--- Bender.yml
package:
  name: i3c_phy_integration_wrapper

sources:
  - hw/i3c_pkg.sv
  - hw/ahb_csr.sv
  - hw/i2c_byte_ctrl.sv
  - hw/i3c_phy.sv
  - hw/i3c_phy_integration_wrapper.sv
  - target: simulation
    files:
      - tb/i2c_target_model.sv
      - tb/tb_i3c_phy_integration_wrapper.sv
